// File: project.f
hw/fetch_pkg.sv
hw/fetch_ctrl.sv
hw/pc_gen.sv
hw/imem_model.sv
hw/insn_fetch.sv
hw/fetch_top.sv
test/fetch_asserts.sv
test/fetch_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e

# Build the testbench with Verilator
verilator --binary --timing --assert -f project.f --top-module fetch_tb -o fetch_sim

# Run and keep the log
./obj_dir/fetch_sim | tee sim.log

# Pass only if the pass line is in the log
grep -q "PASS: all tests" sim.log
echo "Simulation passed"

// File: test/fetch_tb.sv
`timescale 1ns/1ns

module fetch_tb import fetch_pkg::*; ();

	localparam int ROWS = 11;

	logic             clk = 1'b0;
	logic             reset_i;
	logic             stall_i;
	logic             branch_i;
	logic [XLEN-1:0]  branch_pc_i;
	logic [XLEN-1:0]  insn_o;
	logic [XLEN-1:0]  pc_o;
	logic             insn_valid_o;
	logic [EXC_W-1:0] except_o;
	logic             saving_o;

	// Stimulus table with one row per segment
	int unsigned      stall_max [ROWS];
	logic             do_branch [ROWS];
	logic [XLEN-1:0]  target    [ROWS];
	int unsigned      n_accept  [ROWS];

	// Reference model state
	logic [XLEN-1:0]  exp_pc;
	logic [EXC_W-1:0] exp_exc;
	int unsigned      accepted;
	int unsigned      exc_seen;
	int unsigned      exc_planned;
	int unsigned      saves_seen;
	int unsigned      saves_planned;
	logic [31:0]      rng;

	fetch_top UUT (
		.clk          (clk),
		.reset_i      (reset_i),
		.stall_i      (stall_i),
		.branch_i     (branch_i),
		.branch_pc_i  (branch_pc_i),
		.insn_o       (insn_o),
		.pc_o         (pc_o),
		.insn_valid_o (insn_valid_o),
		.except_o     (except_o),
		.saving_o     (saving_o)
	);

	// 8 ns clock
	always #4 clk = ~clk;

	//////////////////////////////
	// Reference helpers
	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// ROM content rule by word index
	function automatic logic [XLEN-1:0] expected_insn(input logic [XLEN-1:0] pc);
		logic [XLEN-1:0] idx;
		idx = pc >> 2;
		return (idx * 32'h9E37_79B1) ^ 32'h00A5_0000;
	endfunction

	// Region rules in priority order
	function automatic logic [EXC_W-1:0] region_exc(input logic [XLEN-1:0] adr);
		logic [EXC_W-1:0] e;
		e = '0;
		if (adr >= PAGE_LO && adr <= PAGE_HI)
			e[1] = 1'b1;
		else if (adr >= TLB_BASE)
			e[0] = 1'b1;
		else if ((adr >> 2) >= ROM_WORDS)
			e[2] = 1'b1;
		return e;
	endfunction

	function automatic logic [XLEN-1:0] vector_of(input logic [EXC_W-1:0] e);
		if (e[0])
			return VEC_TLB;
		else if (e[1])
			return VEC_PAGE;
		return VEC_BUS;
	endfunction

	//////////////////////////////
	// Failure and compare tasks
	task automatic abort_run();
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic insn_compare(input string sig, input logic [XLEN-1:0] got,
			input logic [XLEN-1:0] exp);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s = %h, expected %h", $time, sig, got, exp);
			abort_run();
		end
	endtask

	task automatic pc_compare(input string sig, input logic [XLEN-1:0] got,
			input logic [XLEN-1:0] exp);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s = %h, expected %h", $time, sig, got, exp);
			abort_run();
		end
	endtask

	task automatic exc_compare(input string sig, input logic [EXC_W-1:0] got,
			input logic [EXC_W-1:0] exp);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s = %b, expected %b", $time, sig, got, exp);
			abort_run();
		end
	endtask

	//////////////////////////////
	// Stimulus
	task automatic set_row(input int r, input int unsigned smax, input logic br,
			input logic [XLEN-1:0] tgt, input int unsigned n);
		stall_max[r] = smax;
		do_branch[r] = br;
		target[r]    = tgt;
		n_accept[r]  = n;
		// Every stall segment catches exactly one response
		if (smax != 0)
			saves_planned++;
		if (br && region_exc(tgt) != '0)
			exc_planned++;
	endtask

	task automatic load_table();
		set_row(0,  0, 1'b0, 32'h0,         6);
		set_row(1,  4, 1'b0, 32'h0,         5);
		set_row(2,  0, 1'b1, 32'h0000_0300, 5);
		set_row(3,  3, 1'b1, 32'h0000_0480, 4);
		// Page fault, TLB miss, bus error
		set_row(4,  0, 1'b1, 32'h0000_2040, 4);
		set_row(5,  2, 1'b0, 32'h0,         3);
		set_row(6,  0, 1'b1, 32'h0000_9000, 4);
		set_row(7,  0, 1'b1, 32'h0000_1000, 4);
		set_row(8,  5, 1'b0, 32'h0,         6);
		set_row(9,  0, 1'b1, 32'h0000_0F00, 3);
		set_row(10, 3, 1'b1, 32'h0000_0040, 5);
	endtask

	// At least 3 cycles, so a response always lands in the stall
	task automatic apply_stall(input int unsigned smax);
		int unsigned len;
		rng = xorshift(rng);
		len = 3 + (rng % smax);
		@(posedge clk);
		stall_i <= 1'b1;
		repeat (len) @(posedge clk);
		stall_i <= 1'b0;
	endtask

	task automatic apply_branch(input logic [XLEN-1:0] tgt);
		@(posedge clk);
		branch_i    <= 1'b1;
		branch_pc_i <= tgt;
		@(posedge clk);
		branch_i    <= 1'b0;
	endtask

	task automatic wait_accepted(input int unsigned n);
		int unsigned goal;
		goal = accepted + n;
		while (accepted < goal)
			@(posedge clk);
	endtask

	//////////////////////////////
	// Reference model and checks at mid-cycle
	always @(negedge clk) begin
		if (!reset_i) begin
			if (saving_o) begin
				if (!stall_i) begin
					$display("saving_o pulsed at %0t ns while stall_i was low", $time);
					abort_run();
				end
				saves_seen++;
			end
			if (stall_i && insn_valid_o) begin
				$display("insn_valid_o went high at %0t ns while stall_i was high", $time);
				abort_run();
			end
			// Exception redirects the expected stream
			if (except_o != '0) begin
				exc_compare("except_o", except_o, exp_exc);
				exp_pc  = vector_of(exp_exc);
				exp_exc = '0;
				exc_seen++;
			end
			if (insn_valid_o) begin
				pc_compare("pc_o", pc_o, exp_pc);
				insn_compare("insn_o", insn_o, expected_insn(exp_pc));
				exp_pc = exp_pc + 32'd4;
				accepted++;
			end
			// Branch target and any error expected from its region
			if (branch_i) begin
				exp_pc  = {branch_pc_i[XLEN-1:2], 2'b00};
				exp_exc = region_exc(branch_pc_i);
			end
		end
	end

	// Main sequence
	initial begin
		int r;
		reset_i       = 1'b1;
		stall_i       = 1'b0;
		branch_i      = 1'b0;
		branch_pc_i   = '0;
		exp_pc        = RESET_PC;
		exp_exc       = '0;
		accepted      = 0;
		exc_seen      = 0;
		exc_planned   = 0;
		saves_seen    = 0;
		saves_planned = 0;
		rng           = 32'd99941;
		load_table();
		repeat (5) @(posedge clk);
		reset_i <= 1'b0;
		for (r = 0; r < ROWS; r++) begin
			if (stall_max[r] != 0)
				apply_stall(stall_max[r]);
			if (do_branch[r])
				apply_branch(target[r]);
			wait_accepted(n_accept[r]);
		end
		if (saves_seen == saves_planned && exc_seen == exc_planned) begin
			$display("PASS: all tests");
			$finish;
		end else begin
			$display("Run ended with %0d of %0d saves and %0d of %0d exceptions seen",
				saves_seen, saves_planned, exc_seen, exc_planned);
			abort_run();
		end
	end

	// Watchdog sized from the table
	initial begin
		int unsigned units;
		int r;
		#1;
		units = 0;
		for (r = 0; r < ROWS; r++)
			units += n_accept[r] + stall_max[r] + 5;
		#(units * (IMEM_LAT + 4) * 8 + 400);
		$display("Timeout: the table did not finish in the expected time");
		abort_run();
	end

endmodule

// File: test/fetch_asserts.sv
`timescale 1ns/1ns

module fetch_asserts import fetch_pkg::*; (
	input logic             clk,
	input logic             reset_i,
	input logic             ack_i,
	input logic             err_i,
	input logic             flush_i,
	input logic             saving_i,
	input logic             saved_i,
	input logic [XLEN-1:0]  addr_saved_i,
	input logic [EXC_W-1:0] except_i
);

	//////////////////////////////
	// Save slot
	save_sets_flag: assert property (@(posedge clk) disable iff (reset_i)
		saving_i |=> saved_i)
		else $error("saved flag not set after a save");

	flush_clears_addr: assert property (@(posedge clk) disable iff (reset_i)
		flush_i |=> (addr_saved_i == '0))
		else $error("saved address not cleared by a flush");

	// Exception and bus strobes
	except_onehot: assert property (@(posedge clk) disable iff (reset_i)
		$onehot0(except_i))
		else $error("more than one exception bit set");

	ack_err_apart: assert property (@(posedge clk) disable iff (reset_i)
		!(ack_i && err_i))
		else $error("ack and err high together");

endmodule

bind insn_fetch fetch_asserts u_asserts (
	.clk          (clk),
	.reset_i      (reset_i),
	.ack_i        (icpu_ack_i),
	.err_i        (icpu_err_i),
	.flush_i      (if_flushpipe_i),
	.saving_i     (saving_if_insn_o),
	.saved_i      (saved),
	.addr_saved_i (addr_saved),
	.except_i     (if_except_o)
);

// File: hw/fetch_top.sv
`timescale 1ns/1ns

module fetch_top import fetch_pkg::*; (
	input  logic             clk,
	input  logic             reset_i,
	input  logic             stall_i,
	input  logic             branch_i,
	input  logic [XLEN-1:0]  branch_pc_i,
	output logic [XLEN-1:0]  insn_o,
	output logic [XLEN-1:0]  pc_o,
	output logic             insn_valid_o,
	output logic [EXC_W-1:0] except_o,
	output logic             saving_o
);

	// PC to memory
	logic [XLEN-1:0]  fetch_adr;

	// Memory response
	logic [XLEN-1:0]  icpu_dat;
	logic             icpu_ack;
	logic             icpu_err;
	logic [TAG_W-1:0] icpu_tag;
	logic [XLEN-1:0]  icpu_adr;

	// Stage status
	logic             if_stall;
	logic             genpc_refetch;

	// Control commands
	logic             if_freeze;
	logic             if_flushpipe;
	logic             redirect;
	logic [XLEN-1:0]  redirect_pc;

	//////////////////////////////
	fetch_ctrl u_ctrl (
		.clk            (clk),
		.reset_i        (reset_i),
		.stall_i        (stall_i),
		.branch_i       (branch_i),
		.branch_pc_i    (branch_pc_i),
		.if_stall_i     (if_stall),
		.if_except_i    (except_o),
		.if_freeze_o    (if_freeze),
		.if_flushpipe_o (if_flushpipe),
		.redirect_o     (redirect),
		.redirect_pc_o  (redirect_pc),
		.insn_valid_o   (insn_valid_o)
	);

	pc_gen u_pc (
		.clk             (clk),
		.reset_i         (reset_i),
		.if_freeze_i     (if_freeze),
		.if_stall_i      (if_stall),
		.genpc_refetch_i (genpc_refetch),
		.redirect_i      (redirect),
		.redirect_pc_i   (redirect_pc),
		.fetch_adr_o     (fetch_adr)
	);

	imem_model u_imem (
		.clk         (clk),
		.reset_i     (reset_i),
		.fetch_adr_i (fetch_adr),
		.icpu_dat_o  (icpu_dat),
		.icpu_ack_o  (icpu_ack),
		.icpu_err_o  (icpu_err),
		.icpu_tag_o  (icpu_tag),
		.icpu_adr_o  (icpu_adr)
	);

	insn_fetch u_if (
		.clk              (clk),
		.reset_i          (reset_i),
		.icpu_dat_i       (icpu_dat),
		.icpu_ack_i       (icpu_ack),
		.icpu_err_i       (icpu_err),
		.icpu_tag_i       (icpu_tag),
		.icpu_adr_i       (icpu_adr),
		.if_freeze_i      (if_freeze),
		.if_flushpipe_i   (if_flushpipe),
		.if_insn_o        (insn_o),
		.if_pc_o          (pc_o),
		.if_stall_o       (if_stall),
		.saving_if_insn_o (saving_o),
		.genpc_refetch_o  (genpc_refetch),
		.if_except_o      (except_o)
	);

endmodule

// File: hw/insn_fetch.sv
`timescale 1ns/1ns

module insn_fetch import fetch_pkg::*; (
	input  logic             clk,
	input  logic             reset_i,
	input  logic [XLEN-1:0]  icpu_dat_i,
	input  logic             icpu_ack_i,
	input  logic             icpu_err_i,
	input  logic [TAG_W-1:0] icpu_tag_i,
	input  logic [XLEN-1:0]  icpu_adr_i,
	input  logic             if_freeze_i,
	input  logic             if_flushpipe_i,
	output logic [XLEN-1:0]  if_insn_o,
	output logic [XLEN-1:0]  if_pc_o,
	output logic             if_stall_o,
	output logic             saving_if_insn_o,
	output logic             genpc_refetch_o,
	output logic [EXC_W-1:0] if_except_o
);

	logic             resp;
	logic             clr_bypass;
	logic             if_bypass;
	logic             bypass_q;
	logic             live_ok;
	logic [EXC_W-1:0] live_exc;
	logic             save_insn;
	logic             saved;
	logic [XLEN-1:0]  insn_saved;
	logic [XLEN-1:0]  addr_saved;
	logic [EXC_W-1:0] err_saved;
	logic [XLEN-1:0]  live_pc;

	assign resp    = icpu_ack_i | icpu_err_i;
	assign live_pc = {icpu_adr_i[XLEN-1:2], 2'b00};

	//////////////////////////////
	// Bypass after flush
	// Odd echoed address on a response = first word after redirect
	assign clr_bypass = resp & icpu_adr_i[0];
	assign if_bypass  = clr_bypass ? 1'b0 : (bypass_q | if_flushpipe_i);

	always_ff @(posedge clk) begin
		if (reset_i)
			bypass_q <= 1'b0;
		else
			bypass_q <= if_bypass;
	end

	// Same gate without the flush term
	// keeps the exception path free of the flush loop
	assign live_ok = clr_bypass | ~bypass_q;

	// Tag decode of the live response
	assign live_exc[EXC_TLB]  = icpu_err_i & (icpu_tag_i == TAG_TE);
	assign live_exc[EXC_PAGE] = icpu_err_i & (icpu_tag_i == TAG_PE);
	assign live_exc[EXC_BUS]  = icpu_err_i & (icpu_tag_i == TAG_BE);

	//////////////////////////////
	// Save while frozen
	// Only one slot, a bypassed response is never kept
	assign save_insn        = resp & if_freeze_i & ~saved & ~if_bypass;
	assign saving_if_insn_o = ~if_flushpipe_i & save_insn;

	// Saved flag
	always_ff @(posedge clk) begin
		if (reset_i)
			saved <= 1'b0;
		else if (if_flushpipe_i)
			saved <= 1'b0;
		else if (save_insn)
			saved <= 1'b1;
		else if (!if_freeze_i)
			saved <= 1'b0;
	end

	// Saved word, address and error bits
	always_ff @(posedge clk) begin
		if (if_flushpipe_i) begin
			insn_saved <= NOP_FLUSH;
			addr_saved <= '0;
			err_saved  <= '0;
		end else if (save_insn) begin
			// Error responses carry no usable word
			insn_saved <= icpu_err_i ? NOP_FLUSH : icpu_dat_i;
			addr_saved <= live_pc;
			err_saved  <= live_exc;
		end else if (!if_freeze_i) begin
			insn_saved <= NOP_FLUSH;
			addr_saved <= live_pc;
			err_saved  <= '0;
		end
	end

	//////////////////////////////
	// Stage outputs
	always_comb begin
		if (if_bypass)
			if_insn_o = NOP_FLUSH;
		else if (saved)
			if_insn_o = insn_saved;
		else if (icpu_ack_i)
			if_insn_o = icpu_dat_i;
		else
			if_insn_o = NOP_STALL;
	end

	assign if_pc_o = saved ? addr_saved : live_pc;

	// Nothing to hand over, or bypass still open
	assign if_stall_o      = if_bypass | (~icpu_err_i & ~icpu_ack_i & ~saved);
	assign genpc_refetch_o = saved & icpu_ack_i;

	// Reported only while the pipe moves
	always_comb begin
		if (if_freeze_i)
			if_except_o = '0;
		else if (saved)
			if_except_o = err_saved;
		else if (live_ok)
			if_except_o = live_exc;
		else
			if_except_o = '0;
	end

endmodule

// File: hw/imem_model.sv
`timescale 1ns/1ns

module imem_model import fetch_pkg::*; (
	input  logic             clk,
	input  logic             reset_i,
	input  logic [XLEN-1:0]  fetch_adr_i,
	output logic [XLEN-1:0]  icpu_dat_o,
	output logic             icpu_ack_o,
	output logic             icpu_err_o,
	output logic [TAG_W-1:0] icpu_tag_o,
	output logic [XLEN-1:0]  icpu_adr_o
);

	logic [XLEN-1:0]  adr_q;
	logic             change;
	logic             pend_q;
	logic [CNT_W-1:0] cnt_q;
	logic             fire;
	logic             ack_q;
	logic             err_q;
	logic [TAG_W-1:0] tag_q;
	logic [XLEN-1:0]  dat_q;
	logic [XLEN-1:0]  word_adr;
	logic [XLEN-1:0]  word_idx;
	logic             resp_ok;
	logic [TAG_W-1:0] resp_tag;

	// New request whenever the address moves
	assign change = fetch_adr_i != adr_q;

	// Counter expiry, unless the address moved again
	assign fire = pend_q & ~change & (cnt_q == CNT_W'(1));

	assign word_adr = {adr_q[XLEN-1:2], 2'b00};
	assign word_idx = {2'b00, adr_q[XLEN-1:2]};

	//////////////////////////////
	// Region check, in priority order
	always_comb begin
		resp_ok  = 1'b0;
		resp_tag = '0;
		if (word_adr >= PAGE_LO && word_adr <= PAGE_HI)
			resp_tag = TAG_PE;
		else if (word_adr >= TLB_BASE)
			resp_tag = TAG_TE;
		else if (word_idx >= ROM_WORDS)
			resp_tag = TAG_BE;
		else
			resp_ok = 1'b1;
	end

	// Latency counter and strobes
	always_ff @(posedge clk) begin
		if (reset_i) begin
			// All ones never matches a fetch, so the first one starts
			adr_q  <= '1;
			pend_q <= 1'b0;
			cnt_q  <= '0;
			ack_q  <= 1'b0;
			err_q  <= 1'b0;
		end else begin
			adr_q <= fetch_adr_i;
			ack_q <= fire & resp_ok;
			err_q <= fire & ~resp_ok;
			if (change) begin
				pend_q <= 1'b1;
				cnt_q  <= CNT_W'(IMEM_LAT - 1);
			end else if (fire) begin
				pend_q <= 1'b0;
			end else if (pend_q) begin
				cnt_q <= cnt_q - 1'b1;
			end
		end
	end

	// Response payload
	always_ff @(posedge clk) begin
		if (fire) begin
			dat_q <= resp_ok ? rom_word(word_idx) : '0;
			tag_q <= resp_tag;
		end
	end

	// A response is dropped if the PC left its address
	assign icpu_ack_o = ack_q & ~change;
	assign icpu_err_o = err_q & ~change;
	assign icpu_dat_o = dat_q;
	assign icpu_tag_o = tag_q;
	// Word address plus the redirect mark in bit 0
	assign icpu_adr_o = adr_q;

endmodule

// File: hw/pc_gen.sv
`timescale 1ns/1ns

module pc_gen import fetch_pkg::*; (
	input  logic            clk,
	input  logic            reset_i,
	input  logic            if_freeze_i,
	input  logic            if_stall_i,
	input  logic            genpc_refetch_i,
	input  logic            redirect_i,
	input  logic [XLEN-1:0] redirect_pc_i,
	output logic [XLEN-1:0] fetch_adr_o
);

	logic [XLEN-1:0] pc_q;
	logic            redir_q;
	logic            advance;

	// Step only when the stage has taken the current word
	assign advance = ~if_stall_i & ~if_freeze_i & ~genpc_refetch_i;

	//////////////////////////////
	// PC register
	always_ff @(posedge clk) begin
		if (reset_i) begin
			pc_q    <= RESET_PC;
			redir_q <= 1'b0;
		end else if (redirect_i) begin
			// Target is forced word aligned
			pc_q    <= {redirect_pc_i[XLEN-1:2], 2'b00};
			redir_q <= 1'b1;
		end else if (advance) begin
			pc_q    <= pc_q + 32'd4;
			redir_q <= 1'b0;
		end
	end

	// Bit 0 marks a fetch that follows a redirect
	// Echoed back by the memory, it ends the stage bypass
	// Bit 1 stays clear
	assign fetch_adr_o = {pc_q[XLEN-1:2], 1'b0, redir_q};

endmodule

// File: hw/fetch_ctrl.sv
`timescale 1ns/1ns

module fetch_ctrl import fetch_pkg::*; (
	input  logic             clk,
	input  logic             reset_i,
	input  logic             stall_i,
	input  logic             branch_i,
	input  logic [XLEN-1:0]  branch_pc_i,
	input  logic             if_stall_i,
	input  logic [EXC_W-1:0] if_except_i,
	output logic             if_freeze_o,
	output logic             if_flushpipe_o,
	output logic             redirect_o,
	output logic [XLEN-1:0]  redirect_pc_o,
	output logic             insn_valid_o
);

	logic            exc_take;
	logic [XLEN-1:0] exc_vec;
	logic [XLEN-1:0] target;
	logic            redir_q;
	logic [XLEN-1:0] target_q;

	// Freeze is a plain level from the outside stall
	assign if_freeze_o = stall_i;

	// Fetch exceptions only count while the pipe moves
	assign exc_take = (|if_except_i) & ~stall_i;

	// Vector per exception bit, one-hot from the stage
	always_comb begin
		exc_vec = VEC_BUS;
		if (if_except_i[EXC_TLB])
			exc_vec = VEC_TLB;
		else if (if_except_i[EXC_PAGE])
			exc_vec = VEC_PAGE;
	end

	// Exception wins over a branch in the same cycle
	assign target = exc_take ? exc_vec : branch_pc_i;

	// Flush in the cycle of the request
	assign if_flushpipe_o = exc_take | branch_i;

	//////////////////////////////
	// Redirect shadow
	// Held one more cycle, so the PC keeps the target
	// while the flush settles in the stage
	always_ff @(posedge clk) begin
		if (reset_i) begin
			redir_q <= 1'b0;
		end else begin
			redir_q <= if_flushpipe_o;
		end
	end

	always_ff @(posedge clk) begin
		if (if_flushpipe_o)
			target_q <= target;
	end

	// Fresh request overrides the shadow copy
	assign redirect_o    = if_flushpipe_o | redir_q;
	assign redirect_pc_o = if_flushpipe_o ? target : target_q;

	// Accepted instruction strobe
	// no flush, no shadow, stage has something, not frozen
	assign insn_valid_o = ~if_stall_i & ~stall_i & ~if_flushpipe_o & ~redir_q;

endmodule

// File: hw/fetch_pkg.sv
package fetch_pkg;

	//////////////////////////////
	// Widths
	localparam int XLEN  = 32;
	localparam int TAG_W = 4;
	localparam int EXC_W = 3;

	// Exception vector bit positions
	localparam int EXC_TLB  = 0;
	localparam int EXC_PAGE = 1;
	localparam int EXC_BUS  = 2;

	// Error tags on the instruction bus
	localparam logic [TAG_W-1:0] TAG_TE = 4'hd;
	localparam logic [TAG_W-1:0] TAG_PE = 4'hc;
	localparam logic [TAG_W-1:0] TAG_BE = 4'hb;

	// NOP words, flush flavour and no-ack flavour
	localparam logic [5:0]      OP_NOP    = 6'b000101;
	localparam logic [XLEN-1:0] NOP_FLUSH = {OP_NOP, 26'h041_0000};
	localparam logic [XLEN-1:0] NOP_STALL = {OP_NOP, 26'h061_0000};

	//////////////////////////////
	// Exception vectors and boot address
	localparam logic [XLEN-1:0] VEC_TLB  = 32'h0000_0A00;
	localparam logic [XLEN-1:0] VEC_PAGE = 32'h0000_0400;
	localparam logic [XLEN-1:0] VEC_BUS  = 32'h0000_0200;
	localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0100;

	// Memory map of the instruction ROM
	localparam int unsigned     ROM_WORDS = 1024;
	localparam logic [XLEN-1:0] PAGE_LO   = 32'h0000_2000;
	localparam logic [XLEN-1:0] PAGE_HI   = 32'h0000_2FFF;
	localparam logic [XLEN-1:0] TLB_BASE  = 32'h0000_8000;

	// Response latency, counter sized to hold it
	localparam int IMEM_LAT = 2;
	localparam int CNT_W    = $clog2(IMEM_LAT + 1);

	// ROM content by word index
	function automatic logic [XLEN-1:0] rom_word(input logic [XLEN-1:0] idx);
		return (idx * 32'h9E37_79B1) ^ 32'h00A5_0000;
	endfunction

endpackage
